// ==== Bender.yml ====
package:
  name: conv_pool

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/conv_pool_pkg.sv
      - hdl/line_buffer.sv
      - hdl/window_control.sv
      - hdl/kernel_store.sv
      - hdl/conv55.sv
      - hdl/maxpool22.sv
      - hdl/conv_pool_top.sv
  - target: test
    files:
      - verification/tb_conv_pool.sv

// ==== hdl/conv55.sv ====
`timescale 1ns/1ps
`include "conv_pool_macros.svh"

// 5x5 correlation + bias + relu for one feature map
module conv55 (
	input logic clk,
	input logic rst,
	input logic pixel_en,
	input logic win_valid,
	input conv_pool_pkg::pixel_t pixel,
	input conv_pool_pkg::pixel_t r1,
	input conv_pool_pkg::pixel_t r2,
	input conv_pool_pkg::pixel_t r3,
	input conv_pool_pkg::pixel_t r4,
	input logic [(`CP_TAPS-1)*`CP_W_W-1:0] weights,
	input conv_pool_pkg::weight_t bias,
	output conv_pool_pkg::acc_t conv_value
);

	conv_pool_pkg::pixel_t col_in [`CP_K]; // live right column, top row first
	conv_pool_pkg::pixel_t win_q [`CP_K][`CP_K-1]; // four older columns
	conv_pool_pkg::pixel_t win [`CP_K][`CP_K]; // full window [row][col]
	conv_pool_pkg::acc_t mac_sum;

	assign col_in[0] = r4; // top of window
	assign col_in[1] = r3;
	assign col_in[2] = r2;
	assign col_in[3] = r1;
	assign col_in[4] = pixel;

	// shift left one column per pixel
	always_ff @(posedge clk) begin
		if (pixel_en) begin
			for (int i = 0; i < `CP_K; i++) begin
				for (int j = 0; j < `CP_K - 2; j++)
					win_q[i][j] <= win_q[i][j+1];
				win_q[i][`CP_K-2] <= col_in[i];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `CP_K; i++) begin
			for (int j = 0; j < `CP_K - 1; j++)
				win[i][j] = win_q[i][j];
			win[i][`CP_K-1] = col_in[i];
		end
	end

	// tap 5*i+j weighs row offset i, col offset j
	always_comb begin
		mac_sum = conv_pool_pkg::acc_t'(bias); // sign extended
		for (int i = 0; i < `CP_K; i++)
			for (int j = 0; j < `CP_K; j++)
				mac_sum = mac_sum + conv_pool_pkg::acc_t'(win[i][j]) *
					conv_pool_pkg::acc_t'($signed(weights[(`CP_K*i+j)*`CP_W_W +: `CP_W_W]));
	end

	always_ff @(posedge clk) begin
		if (rst)
			conv_value <= '0;
		else if (win_valid)
			conv_value <= mac_sum[`CP_ACC_W-1] ? '0 : mac_sum; // relu
	end

endmodule

// ==== hdl/conv_pool_macros.svh ====
`ifndef CONV_POOL_MACROS_SVH
`define CONV_POOL_MACROS_SVH

// image geometry, raster order
`define CP_IMG_COLS 10
`define CP_IMG_ROWS 10

// kernel side, square 5x5
`define CP_K 5
`define CP_CONV_COLS 6 // image width minus 4

// two feature maps
`define CP_MAPS 2
`define CP_TAPS 26 // 25 weights + bias at tap 25

// datapath widths
`define CP_PIX_W 8
`define CP_W_W 8
`define CP_ACC_W 24 // 25 products of 8x8 plus bias, no overflow

`endif

// ==== hdl/conv_pool_pkg.sv ====
`include "conv_pool_macros.svh"

package conv_pool_pkg;

	typedef logic signed [`CP_PIX_W-1:0] pixel_t; // input pixel
	typedef logic signed [`CP_W_W-1:0] weight_t; // weight or bias
	typedef logic signed [`CP_ACC_W-1:0] acc_t; // conv sum and pooled value

	// position counters
	typedef logic [$clog2(`CP_IMG_COLS)-1:0] col_t;
	typedef logic [$clog2(`CP_IMG_ROWS)-1:0] row_t;

	typedef logic [$clog2(`CP_TAPS)-1:0] tap_t; // 0..24 weights, 25 bias
	typedef logic [$clog2(`CP_MAPS)-1:0] map_t;

	// frame control
	typedef enum logic [1:0] {
		FILL, // fewer than five rows seen
		RUN,
		DONE // one cycle, pulses frame_done
	} frame_state_t;

endpackage

// ==== hdl/conv_pool_top.sv ====
`timescale 1ns/1ps
`include "conv_pool_macros.svh"

module conv_pool_top (
	input logic clk,
	input logic rst,
	input logic pixel_en,
	input conv_pool_pkg::pixel_t pixel,
	input logic weight_we,
	input conv_pool_pkg::map_t weight_map,
	input conv_pool_pkg::tap_t weight_tap,
	input conv_pool_pkg::weight_t weight_data,
	output logic pool_valid,
	output conv_pool_pkg::acc_t pool_out0,
	output conv_pool_pkg::acc_t pool_out1,
	output logic frame_done
);

	conv_pool_pkg::pixel_t r1, r2, r3, r4; // rows above current pixel
	logic win_valid, conv_shift, pool_take;
	logic [(`CP_TAPS-1)*`CP_W_W-1:0] weights [`CP_MAPS];
	conv_pool_pkg::weight_t bias [`CP_MAPS];
	conv_pool_pkg::acc_t conv_value [`CP_MAPS];
	conv_pool_pkg::acc_t pool_value [`CP_MAPS];
	logic [`CP_MAPS-1:0] pool_vld;

	line_buffer #(.COLS(`CP_IMG_COLS), .DATA_W(`CP_PIX_W)) u_lb (.clk(clk), .rst(rst),
		.en(pixel_en), .din(pixel), .r1(r1), .r2(r2), .r3(r3), .r4(r4));

	window_control u_ctrl (.clk(clk), .rst(rst), .pixel_en(pixel_en), .win_valid(win_valid),
		.conv_shift(conv_shift), .pool_take(pool_take), .frame_done(frame_done));

	kernel_store u_ks (.clk(clk), .rst(rst), .weight_we(weight_we), .weight_map(weight_map),
		.weight_tap(weight_tap), .weight_data(weight_data), .weights0(weights[0]),
		.weights1(weights[1]), .bias0(bias[0]), .bias1(bias[1]));

	for (genvar m = 0; m < `CP_MAPS; m++) begin : g_map
		conv55 u_conv (.clk(clk), .rst(rst), .pixel_en(pixel_en), .win_valid(win_valid),
			.pixel(pixel), .r1(r1), .r2(r2), .r3(r3), .r4(r4), .weights(weights[m]),
			.bias(bias[m]), .conv_value(conv_value[m]));
		maxpool22 u_pool (.clk(clk), .rst(rst), .conv_shift(conv_shift), .pool_take(pool_take),
			.conv_value(conv_value[m]), .pool_valid(pool_vld[m]), .pool_value(pool_value[m]));
	end

	assign pool_valid = &pool_vld; // maps run in lockstep
	assign pool_out0 = pool_value[0];
	assign pool_out1 = pool_value[1];

endmodule

// ==== hdl/kernel_store.sv ====
`timescale 1ns/1ps
`include "conv_pool_macros.svh"

// writable weights and bias per map, written between frames
module kernel_store (
	input logic clk,
	input logic rst,
	input logic weight_we,
	input conv_pool_pkg::map_t weight_map,
	input conv_pool_pkg::tap_t weight_tap,
	input conv_pool_pkg::weight_t weight_data,
	output logic [(`CP_TAPS-1)*`CP_W_W-1:0] weights0,
	output logic [(`CP_TAPS-1)*`CP_W_W-1:0] weights1,
	output conv_pool_pkg::weight_t bias0,
	output conv_pool_pkg::weight_t bias1
);

	conv_pool_pkg::weight_t taps [`CP_MAPS][`CP_TAPS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int m = 0; m < `CP_MAPS; m++)
				for (int t = 0; t < `CP_TAPS; t++)
					taps[m][t] <= '0;
		end else if (weight_we && weight_tap < `CP_TAPS) begin
			taps[weight_map][weight_tap] <= weight_data; // visible next cycle
		end
	end

	// flatten, tap t at bits [t*W +: W]
	always_comb begin
		for (int t = 0; t < `CP_TAPS - 1; t++) begin
			weights0[t*`CP_W_W +: `CP_W_W] = taps[0][t];
			weights1[t*`CP_W_W +: `CP_W_W] = taps[1][t];
		end
	end

	assign bias0 = taps[0][`CP_TAPS-1]; // tap 25
	assign bias1 = taps[1][`CP_TAPS-1];

	a_tap_range: assert property (@(posedge clk) disable iff (rst)
		weight_we |-> weight_tap < `CP_TAPS);

endmodule

// ==== hdl/line_buffer.sv ====
`timescale 1ns/1ps

// four chained row delay lines, r1 is the row directly above din
module line_buffer #(
	parameter int COLS = 10,
	parameter int DATA_W = 8
) (
	input logic clk,
	input logic rst,
	input logic en,
	input logic [DATA_W-1:0] din,
	output logic [DATA_W-1:0] r1,
	output logic [DATA_W-1:0] r2,
	output logic [DATA_W-1:0] r3,
	output logic [DATA_W-1:0] r4
);

	logic [DATA_W-1:0] dl [4][COLS]; // dl[k] holds row k+1 above

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < 4; k++)
				for (int c = 0; c < COLS; c++)
					dl[k][c] <= '0; // zero fill
		end else if (en) begin
			dl[0][0] <= din;
			for (int k = 1; k < 4; k++)
				dl[k][0] <= dl[k-1][COLS-1]; // tail of one row feeds next
			for (int k = 0; k < 4; k++)
				for (int c = 1; c < COLS; c++)
					dl[k][c] <= dl[k][c-1];
		end
	end

	// oldest entry of each line is the pixel COLS pushes back
	assign r1 = dl[0][COLS-1];
	assign r2 = dl[1][COLS-1];
	assign r3 = dl[2][COLS-1];
	assign r4 = dl[3][COLS-1];

endmodule

// ==== hdl/maxpool22.sv ====
`timescale 1ns/1ps
`include "conv_pool_macros.svh"

// 2x2 stride-2 max over the conv stream of one map
module maxpool22 (
	input logic clk,
	input logic rst,
	input logic conv_shift,
	input logic pool_take,
	input conv_pool_pkg::acc_t conv_value,
	output logic pool_valid,
	output conv_pool_pkg::acc_t pool_value
);

	conv_pool_pkg::acc_t above; // conv row above, same column
	conv_pool_pkg::acc_t prev; // left neighbour
	conv_pool_pkg::acc_t above_prev; // upper left
	conv_pool_pkg::acc_t max_lo;
	conv_pool_pkg::acc_t max_hi;

	// one conv row of delay, deeper lines left open
	line_buffer #(
		.COLS(`CP_CONV_COLS),
		.DATA_W(`CP_ACC_W)
	) u_row_dly (
		.clk(clk),
		.rst(rst),
		.en(conv_shift),
		.din(conv_value),
		.r1(above),
		.r2(),
		.r3(),
		.r4()
	);

	always_ff @(posedge clk) begin
		if (conv_shift) begin
			prev <= conv_value;
			above_prev <= above;
		end
	end

	assign max_lo = (prev > conv_value) ? prev : conv_value;
	assign max_hi = (above_prev > above) ? above_prev : above;

	always_ff @(posedge clk) begin
		if (rst)
			pool_valid <= 1'b0;
		else
			pool_valid <= pool_take;
		if (pool_take)
			pool_value <= (max_hi > max_lo) ? max_hi : max_lo;
	end

	// blocks close at most every other conv output
	a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
		pool_valid |=> !pool_valid);

endmodule

// ==== hdl/window_control.sv ====
`timescale 1ns/1ps
`include "conv_pool_macros.svh"

module window_control (
	input logic clk,
	input logic rst,
	input logic pixel_en,
	output logic win_valid,
	output logic conv_shift,
	output logic pool_take,
	output logic frame_done
);

	conv_pool_pkg::col_t col; // position of the incoming pixel
	conv_pool_pkg::row_t row;
	conv_pool_pkg::frame_state_t state;

	logic last_col;
	logic last_px;

	assign last_col = col == conv_pool_pkg::col_t'(`CP_IMG_COLS - 1);
	assign last_px = last_col && (row == conv_pool_pkg::row_t'(`CP_IMG_ROWS - 1));

	// RUN means row >= 4, so a full 5x5 window exists once col >= 4
	assign win_valid = pixel_en && (state == conv_pool_pkg::RUN) && (col >= 4);

	always_ff @(posedge clk) begin
		if (rst) begin
			col <= '0;
			row <= '0;
			state <= conv_pool_pkg::FILL;
			conv_shift <= 1'b0;
			pool_take <= 1'b0;
		end else begin
			conv_shift <= win_valid; // conv value lands next cycle
			// odd conv row and col closes a 2x2 block
			pool_take <= win_valid && row[0] && col[0];
			if (pixel_en) begin
				col <= last_col ? '0 : col + 1'b1;
				if (last_px)
					row <= '0; // wrap at frame end
				else if (last_col)
					row <= row + 1'b1;
			end
			case (state)
				conv_pool_pkg::FILL:
					if (pixel_en && last_col && row == 3) state <= conv_pool_pkg::RUN;
				conv_pool_pkg::RUN:
					if (pixel_en && last_px) state <= conv_pool_pkg::DONE;
				default: state <= conv_pool_pkg::FILL; // DONE lasts one cycle
			endcase
		end
	end

	assign frame_done = state == conv_pool_pkg::DONE;

	// RUN state tracks rows 4 and up of the row counter
	a_run_rows: assert property (@(posedge clk) disable iff (rst)
		(state == conv_pool_pkg::RUN) == (row >= 4));

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/conv_pool_pkg.sv
hdl/line_buffer.sv
hdl/window_control.sv
hdl/kernel_store.sv
hdl/conv55.sv
hdl/maxpool22.sv
hdl/conv_pool_top.sv
verification/tb_conv_pool.sv

// ==== verification/conv_pool_stim.txt ====
# kernel sets A then B: per map 5 rows of 5 weights (tap 5*i+j) then the bias
# then images 1 and 2 (10 rows of 10 pixels), then expected pooled values A0 A1 B0 B1
1 0 0 0 0
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0
40
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0
0 0 0 0 2
-3
0 0 0 0 0
0 1 0 0 0
0 0 1 0 0
0 0 0 0 0
0 0 0 0 0
5
-1 0 0 0 0
0 0 0 0 0
0 0 -2 0 0
0 0 0 0 0
0 0 0 0 0
90
-50 -49 -48 -47 -46 -45 -44 -43 -42 -41
-40 -39 -38 -37 -36 -35 -34 -33 -32 -31
-30 -29 -28 -27 -26 -25 -24 -23 -22 -21
-20 -19 -18 -17 -16 -15 -14 -13 -12 -11
-10 -9 -8 -7 -6 -5 -4 -3 -2 -1
0 1 2 3 4 5 6 7 8 9
10 11 12 13 14 15 16 17 18 19
20 21 22 23 24 25 26 27 28 29
30 31 32 33 34 35 36 37 38 39
40 41 42 43 44 45 46 47 48 49
40 43 46 49 52 55 58 61 64 67
35 38 41 44 47 50 53 56 59 62
30 33 36 39 42 45 48 51 54 57
25 28 31 34 37 40 43 46 49 52
20 23 26 29 32 35 38 41 44 47
15 18 21 24 27 30 33 36 39 42
10 13 16 19 22 25 28 31 34 37
5 8 11 14 17 20 23 26 29 32
0 3 6 9 12 15 18 21 24 27
-5 -2 1 4 7 10 13 16 19 22
1 3 5
21 23 25
41 43 45
7 11 15
47 51 55
87 91 95
85 97 109
65 77 89
45 57 69
0 0 0
23 5 0
53 35 17

// ==== verification/tb_conv_pool.sv ====
`timescale 1ns/1ps

module tb_conv_pool;

	logic clk = 1'b0;
	logic rst;
	logic pixel_en;
	conv_pool_pkg::pixel_t pixel;
	logic weight_we;
	conv_pool_pkg::map_t weight_map;
	conv_pool_pkg::tap_t weight_tap;
	conv_pool_pkg::weight_t weight_data;
	logic pool_valid;
	conv_pool_pkg::acc_t pool_out0;
	conv_pool_pkg::acc_t pool_out1;
	logic frame_done;

	conv_pool_pkg::weight_t kset [2][2][26]; // [set][map][tap]
	conv_pool_pkg::pixel_t img [2][100]; // raster order
	int exp_val [2][2][9]; // [set][map][block]
	int cur_set; // which expected set the monitor uses
	int res_idx; // pooled results seen this frame
	int done_cnt; // frame_done pulses this frame
	int cyc = 0;
	int blk_q [$]; // drive cycle of each block-completing pixel
	int val_err = 0;
	int oth_err = 0;
	bit stim_ok;
	bit idle_chk; // post-reset quiet check active

	conv_pool_top DUT (.clk(clk), .rst(rst), .pixel_en(pixel_en), .pixel(pixel),
		.weight_we(weight_we), .weight_map(weight_map), .weight_tap(weight_tap),
		.weight_data(weight_data), .pool_valid(pool_valid), .pool_out0(pool_out0),
		.pool_out1(pool_out1), .frame_done(frame_done));

	always #4 clk = ~clk; // 8 ns period

	always @(posedge clk) cyc <= cyc + 1; // stable at the falling edge

	task read_stim;
		int fd;
		int v;
		int rc;
		reg [8*200-1:0] line;
		fd = $fopen("verification/conv_pool_stim.txt", "r");
		stim_ok = fd != 0;
		if (!stim_ok) begin
			oth_err++;
			$display("could not open the stimulus file");
		end else begin
			rc = $fgets(line, fd); // two header lines
			rc = $fgets(line, fd);
			for (int s = 0; s < 2; s++)
				for (int m = 0; m < 2; m++)
					for (int t = 0; t < 26; t++) begin
						rc = $fscanf(fd, "%d", v);
						kset[s][m][t] = v;
					end
			for (int i = 0; i < 2; i++)
				for (int p = 0; p < 100; p++) begin
					rc = $fscanf(fd, "%d", v);
					img[i][p] = v;
				end
			for (int s = 0; s < 2; s++)
				for (int m = 0; m < 2; m++)
					for (int b = 0; b < 9; b++) begin
						rc = $fscanf(fd, "%d", v);
						exp_val[s][m][b] = v;
					end
			assert (rc == 1) else begin
				oth_err++;
				$display("stimulus file ended early");
			end
			$fclose(fd);
		end
	endtask

	task load_kernels(input int s);
		for (int m = 0; m < 2; m++)
			for (int t = 0; t < 26; t++) begin
				@(negedge clk);
				weight_we = 1'b1;
				weight_map = m;
				weight_tap = t;
				weight_data = kset[s][m][t];
			end
		@(negedge clk);
		weight_we = 1'b0;
	endtask

	task send_frame(input int i, input bit gaps);
		int n;
		int r;
		int c;
		for (int p = 0; p < 100; p++) begin
			n = gaps ? $urandom % 4 : 0; // 0 to 3 idle cycles
			repeat (n) begin
				@(negedge clk);
				pixel_en = 1'b0;
			end
			@(negedge clk);
			pixel_en = 1'b1;
			pixel = img[i][p];
			r = p / 10;
			c = p % 10;
			if (r >= 5 && c >= 5 && r[0] && c[0])
				blk_q.push_back(cyc); // closes a 2x2 block
		end
		@(negedge clk);
		pixel_en = 1'b0;
	endtask

	task wait_frame_end;
		int t;
		t = 0;
		while ((res_idx < 9 || done_cnt < 1) && t < 200) begin
			@(negedge clk);
			t++;
		end
		assert (t < 200) else begin
			oth_err++;
			$display("timeout waiting for pooled results and frame_done");
		end
		repeat (4) @(negedge clk); // catch stray pulses
		assert (res_idx == 9 && done_cnt == 1) else begin
			oth_err++;
			$display("frame gave %0d results and %0d frame_done pulses", res_idx, done_cnt);
		end
	endtask

	task run_frame(input int s, input int i, input bit gaps);
		cur_set = s;
		res_idx = 0;
		done_cnt = 0;
		blk_q.delete();
		send_frame(i, gaps);
		wait_frame_end();
	endtask

	// output monitor, outputs sampled mid-cycle
	always @(negedge clk) begin
		if (!rst && idle_chk) begin
			assert (!pool_valid && !frame_done) else begin
				oth_err++;
				$display("output strobe while idle after reset");
			end
		end
		if (!rst && frame_done) begin
			done_cnt++;
			// last pixel closes block 9, its result lands one cycle later
			assert (res_idx == 8) else begin
				oth_err++;
				$display("frame_done after %0d results, expected 8", res_idx);
			end
		end
		if (!rst && pool_valid) begin
			assert (res_idx < 9 && blk_q.size() > 0) else begin
				oth_err++;
				$display("pool_valid pulse with no block pending");
			end
			if (res_idx < 9 && blk_q.size() > 0) begin
				assert (cyc - blk_q[0] == 2) else begin
					oth_err++;
					$display("pool_valid %0d cycles after its pixel", cyc - blk_q[0]);
				end
				void'(blk_q.pop_front());
				assert (pool_out0 == exp_val[cur_set][0][res_idx]) else begin
					val_err++;
					$display("FAIL pool_out0 exp %h got %h",
						24'(exp_val[cur_set][0][res_idx]), pool_out0);
				end
				assert (pool_out1 == exp_val[cur_set][1][res_idx]) else begin
					val_err++;
					$display("FAIL pool_out1 exp %h got %h",
						24'(exp_val[cur_set][1][res_idx]), pool_out1);
				end
			end
			res_idx++;
		end
	end

	initial begin
		void'($urandom(83));
		rst = 1'b1;
		pixel_en = 1'b0;
		pixel = '0;
		weight_we = 1'b0;
		weight_map = '0;
		weight_tap = '0;
		weight_data = '0;
		idle_chk = 1'b0;
		cur_set = 0;
		res_idx = 0;
		done_cnt = 0;
		read_stim();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		if (stim_ok) begin
			idle_chk = 1'b1; // quiet outputs with no pixels
			repeat (20) @(negedge clk);
			idle_chk = 1'b0;
			load_kernels(0);
			run_frame(0, 0, 1'b0); // set A, image 1, back to back
			run_frame(0, 0, 1'b1); // same frame with gaps
			load_kernels(1);
			run_frame(1, 1, 1'b1); // set B, image 2
		end
		$display("errors: %0d value, %0d other", val_err, oth_err);
		if (val_err + oth_err == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
